// File: hw/uart_dem_macros.svh
// UART debug emulator constants
// Flit and packet sizes, the destination of transmit packets
// and the bit positions in the line status register

`ifndef UART_DEM_MACROS_SVH
`define UART_DEM_MACROS_SVH

`define UART_DEM_FLIT_W 16
`define UART_DEM_PKT_LEN 3

// Host debug module sits at address zero
`define UART_DEM_DEST 16'h0000

`define UART_DEM_LSR_DR 0
`define UART_DEM_LSR_THRE 5
`define UART_DEM_LSR_TEMT 6

`endif

// File: hw/dii_pkg.sv
// Debug interconnect types
// One flit payload word and the packet kinds that travel in the
// top bits of the payload flit

`include "uart_dem_macros.svh"

package dii_pkg;

   // One flit payload on the debug interconnect
   typedef logic [`UART_DEM_FLIT_W-1:0] dii_word_t;

   // Packet kind, held in bits 15:14 of the third flit
   typedef enum logic [1:0] {
      EVT_CHAR  = 2'b01,
      EVT_OTHER = 2'b10
   } dii_evt_e;

endpackage

// File: hw/uart_pkg.sv
// Emulated 16550 types
// Register addresses of the 16550 map and the states of the
// AXI4-Lite bridge in front of it

package uart_pkg;

   // 16550 register map, DLAB has no effect here
   typedef enum logic [2:0] {
      REG_RBR_THR = 3'd0,
      REG_IER     = 3'd1,
      REG_IIR     = 3'd2,
      REG_LCR     = 3'd3,
      REG_MCR     = 3'd4,
      REG_LSR     = 3'd5,
      REG_MSR     = 3'd6,
      REG_SCR     = 3'd7
   } uart_reg_e;

   // Bridge runs one access at a time
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_BUS  = 2'd1,
      ST_RESP = 2'd2
   } bridge_state_e;

endpackage

// File: hw/uart_axil_bridge.sv
// AXI4-Lite slave bridge for the 16550 register file
// Accepts one write or one read at a time, holds it as a register
// request until acknowledged and returns an OKAY response

`timescale 1ns/1ns

module uart_axil_bridge import uart_pkg::*; (
   input  logic       clk,
   input  logic       rst,

   input  logic [2:0] awaddr,
   input  logic       awvalid,
   output logic       awready,
   input  logic [7:0] wdata,
   input  logic       wvalid,
   output logic       wready,
   output logic [1:0] bresp,
   output logic       bvalid,
   input  logic       bready,
   input  logic [2:0] araddr,
   input  logic       arvalid,
   output logic       arready,
   output logic [7:0] rdata,
   output logic [1:0] rresp,
   output logic       rvalid,
   input  logic       rready,

   output logic       bus_req,
   output logic [2:0] bus_addr,
   output logic       bus_write,
   output logic [7:0] bus_wdata,
   input  logic       bus_ack,
   input  logic [7:0] bus_rdata
);

   bridge_state_e state;
   logic          take_wr;
   logic          take_rd;
   logic          resp_done;

   // Write needs both address and data, and wins over a read
   assign take_wr = (state == ST_IDLE) & awvalid & wvalid;
   assign take_rd = (state == ST_IDLE) & arvalid & ~(awvalid & wvalid);

   assign awready = take_wr;
   assign wready  = take_wr;
   assign arready = take_rd;

   assign bus_req = (state == ST_BUS);

   assign bvalid = (state == ST_RESP) & bus_write;
   assign rvalid = (state == ST_RESP) & ~bus_write;
   assign bresp  = 2'b00;
   assign rresp  = 2'b00;

   assign resp_done = (bvalid & bready) | (rvalid & rready);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (take_wr | take_rd) begin
                  state <= ST_BUS;
               end
            end
            ST_BUS: begin
               if (bus_ack) begin
                  state <= ST_RESP;
               end
            end
            ST_RESP: begin
               if (resp_done) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Request latch and read data capture
   always_ff @(posedge clk) begin
      if (take_wr) begin
         bus_addr  <= awaddr;
         bus_write <= 1'b1;
         bus_wdata <= wdata;
      end else if (take_rd) begin
         bus_addr  <= araddr;
         bus_write <= 1'b0;
      end
      if (bus_req & bus_ack) begin
         rdata <= bus_rdata;
      end
   end

endmodule

// File: hw/uart_16550_regs.sv
// 16550 register file
// Holds IER, LCR, MCR and SCR, hands THR writes to the transmit path,
// pops the receive buffer on RBR reads and builds LSR, IIR and irq

`include "uart_dem_macros.svh"
`timescale 1ns/1ns

module uart_16550_regs import uart_pkg::*; (
   input  logic       clk,
   input  logic       rst,

   input  logic       bus_req,
   input  logic [2:0] bus_addr,
   input  logic       bus_write,
   input  logic [7:0] bus_wdata,
   output logic       bus_ack,
   output logic [7:0] bus_rdata,

   output logic [7:0] tx_char,
   output logic       tx_valid,
   input  logic       tx_ready,

   input  logic [7:0] rx_char,
   input  logic       rx_valid,
   output logic       rx_ready,

   output logic       irq
);

   uart_reg_e  reg_sel;
   logic       thr_wr;
   logic       acc;
   logic       ack_q;
   logic       pop_q;
   logic [7:0] rdata_q;
   logic       ier_rx;
   logic [7:0] lcr;
   logic [7:0] mcr;
   logic [7:0] scr;
   logic [7:0] lsr;
   logic [7:0] iir;

   assign reg_sel = uart_reg_e'(bus_addr);

   // THR writes wait on the transmit handshake, all else acks next cycle
   assign thr_wr = bus_req & bus_write & (reg_sel == REG_RBR_THR);
   assign acc    = bus_req & ~ack_q & ~thr_wr;

   assign tx_valid  = thr_wr;
   assign tx_char   = bus_wdata;
   assign bus_ack   = ack_q | (tx_valid & tx_ready);
   assign bus_rdata = rdata_q;
   assign rx_ready  = pop_q;

   always_comb begin
      lsr = 8'h00;
      lsr[`UART_DEM_LSR_DR]   = rx_valid;
      lsr[`UART_DEM_LSR_THRE] = tx_ready;
      lsr[`UART_DEM_LSR_TEMT] = tx_ready;
   end

   // Only the receive data interrupt exists
   assign iir = (rx_valid & ier_rx) ? 8'h04 : 8'h01;

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q  <= 1'b0;
         pop_q  <= 1'b0;
         ier_rx <= 1'b0;
         lcr    <= 8'h00;
         mcr    <= 8'h00;
         scr    <= 8'h00;
         irq    <= 1'b0;
      end else begin
         ack_q <= acc;
         pop_q <= acc & ~bus_write & (reg_sel == REG_RBR_THR) & rx_valid;
         irq   <= rx_valid & ier_rx;
         if (acc & bus_write) begin
            case (reg_sel)
               REG_IER: ier_rx <= bus_wdata[0];
               REG_LCR: lcr    <= bus_wdata;
               REG_MCR: mcr    <= bus_wdata;
               REG_SCR: scr    <= bus_wdata;
               default: ;
            endcase
         end
      end
   end

   // Read data is ready in the ack cycle
   always_ff @(posedge clk) begin
      if (acc) begin
         case (reg_sel)
            REG_RBR_THR: rdata_q <= rx_valid ? rx_char : 8'h00;
            REG_IER:     rdata_q <= {7'b0, ier_rx};
            REG_IIR:     rdata_q <= iir;
            REG_LCR:     rdata_q <= lcr;
            REG_MCR:     rdata_q <= mcr;
            REG_LSR:     rdata_q <= lsr;
            REG_SCR:     rdata_q <= scr;
            default:     rdata_q <= 8'h00;
         endcase
      end
   end

endmodule

// File: hw/dii_char_tx.sv
// Transmit flit path
// Packs one character into a three-flit event packet:
// destination, source id, then kind and character

`include "uart_dem_macros.svh"
`timescale 1ns/1ns

module dii_char_tx import dii_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic [15:0] id,

   input  logic [7:0] tx_char,
   input  logic      tx_valid,
   output logic      tx_ready,

   output dii_word_t debug_out_data,
   output logic      debug_out_last,
   output logic      debug_out_valid,
   input  logic      debug_out_ready
);

   logic       busy;
   logic [1:0] cnt;
   logic [7:0] char_q;

   assign tx_ready        = ~busy;
   assign debug_out_valid = busy;
   assign debug_out_last  = (cnt == 2'(`UART_DEM_PKT_LEN - 1));

   always_comb begin
      case (cnt)
         2'd0:    debug_out_data = `UART_DEM_DEST;
         2'd1:    debug_out_data = id;
         default: debug_out_data = {EVT_CHAR, 6'b0, char_q};
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
         cnt  <= 2'd0;
      end else if (tx_valid & tx_ready) begin
         busy <= 1'b1;
         cnt  <= 2'd0;
      end else if (debug_out_valid & debug_out_ready) begin
         if (debug_out_last) begin
            busy <= 1'b0;
         end else begin
            cnt <= cnt + 2'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tx_valid & tx_ready) begin
         char_q <= tx_char;
      end
   end

endmodule

// File: hw/dii_char_rx.sv
// Receive flit path
// Counts flits per packet and keeps the character of the
// payload flit when its kind is EVT_CHAR, in a one-entry buffer

`include "uart_dem_macros.svh"
`timescale 1ns/1ns

module dii_char_rx import dii_pkg::*; (
   input  logic      clk,
   input  logic      rst,

   input  dii_word_t debug_in_data,
   input  logic      debug_in_last,
   input  logic      debug_in_valid,
   output logic      debug_in_ready,

   output logic [7:0] rx_char,
   output logic      rx_valid,
   input  logic      rx_ready
);

   logic [1:0] cnt;
   logic       take;
   logic       is_char;

   // Stall the input while a character waits
   assign debug_in_ready = ~rx_valid;
   assign take           = debug_in_valid & debug_in_ready;

   assign is_char = debug_in_last &
                    (cnt == 2'(`UART_DEM_PKT_LEN - 1)) &
                    (dii_evt_e'(debug_in_data[15:14]) == EVT_CHAR);

   always_ff @(posedge clk) begin
      if (rst) begin
         cnt      <= 2'd0;
         rx_valid <= 1'b0;
      end else begin
         if (take) begin
            if (debug_in_last) begin
               cnt <= 2'd0;
            end else if (cnt != 2'd3) begin
               cnt <= cnt + 2'd1;
            end
         end
         if (take & is_char) begin
            rx_valid <= 1'b1;
         end else if (rx_ready) begin
            rx_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take & is_char) begin
         rx_char <= debug_in_data[7:0];
      end
   end

endmodule

// File: hw/uart_dem_top.sv
// UART debug emulator top level
// AXI4-Lite bridge, 16550 register file and the two flit paths

`timescale 1ns/1ns

module uart_dem_top import dii_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic [15:0] id,
   output logic       irq,

   input  logic [2:0] awaddr,
   input  logic       awvalid,
   output logic       awready,
   input  logic [7:0] wdata,
   input  logic       wvalid,
   output logic       wready,
   output logic [1:0] bresp,
   output logic       bvalid,
   input  logic       bready,
   input  logic [2:0] araddr,
   input  logic       arvalid,
   output logic       arready,
   output logic [7:0] rdata,
   output logic [1:0] rresp,
   output logic       rvalid,
   input  logic       rready,

   output dii_word_t  debug_out_data,
   output logic       debug_out_last,
   output logic       debug_out_valid,
   input  logic       debug_out_ready,
   input  dii_word_t  debug_in_data,
   input  logic       debug_in_last,
   input  logic       debug_in_valid,
   output logic       debug_in_ready
);

   logic       bus_req;
   logic [2:0] bus_addr;
   logic       bus_write;
   logic [7:0] bus_wdata;
   logic       bus_ack;
   logic [7:0] bus_rdata;
   logic [7:0] tx_char;
   logic       tx_valid;
   logic       tx_ready;
   logic [7:0] rx_char;
   logic       rx_valid;
   logic       rx_ready;

   uart_axil_bridge u_bridge (
      .clk       (clk),
      .rst       (rst),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wvalid    (wvalid),
      .wready    (wready),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready),
      .bus_req   (bus_req),
      .bus_addr  (bus_addr),
      .bus_write (bus_write),
      .bus_wdata (bus_wdata),
      .bus_ack   (bus_ack),
      .bus_rdata (bus_rdata)
   );

   uart_16550_regs u_regs (
      .clk       (clk),
      .rst       (rst),
      .bus_req   (bus_req),
      .bus_addr  (bus_addr),
      .bus_write (bus_write),
      .bus_wdata (bus_wdata),
      .bus_ack   (bus_ack),
      .bus_rdata (bus_rdata),
      .tx_char   (tx_char),
      .tx_valid  (tx_valid),
      .tx_ready  (tx_ready),
      .rx_char   (rx_char),
      .rx_valid  (rx_valid),
      .rx_ready  (rx_ready),
      .irq       (irq)
   );

   dii_char_tx u_tx (
      .clk             (clk),
      .rst             (rst),
      .id              (id),
      .tx_char         (tx_char),
      .tx_valid        (tx_valid),
      .tx_ready        (tx_ready),
      .debug_out_data  (debug_out_data),
      .debug_out_last  (debug_out_last),
      .debug_out_valid (debug_out_valid),
      .debug_out_ready (debug_out_ready)
   );

   dii_char_rx u_rx (
      .clk            (clk),
      .rst            (rst),
      .debug_in_data  (debug_in_data),
      .debug_in_last  (debug_in_last),
      .debug_in_valid (debug_in_valid),
      .debug_in_ready (debug_in_ready),
      .rx_char        (rx_char),
      .rx_valid       (rx_valid),
      .rx_ready       (rx_ready)
   );

endmodule

// File: sim/uart_dem_props.sv
// Handshake properties of the AXI4-Lite bridge
// Bound into every uart_axil_bridge instance

`timescale 1ns/1ns

module uart_dem_props import uart_pkg::*; (
   input logic          clk,
   input logic          rst,
   input logic          bvalid,
   input logic          bready,
   input logic          rvalid,
   input logic          rready,
   input logic [7:0]    rdata,
   input logic          bus_ack,
   input bridge_state_e state
);

   // Only one response channel is active at a time
   resp_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(bvalid && rvalid))
      else $error("bvalid and rvalid high in the same cycle");

   bvalid_hold: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   // Read data stays put while the response waits
   rvalid_hold: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata))
      else $error("rvalid or rdata changed before rready");

   // The register file answers only a pending request
   ack_in_bus_only: assert property (@(posedge clk) disable iff (rst)
      (state != ST_BUS) |-> !bus_ack)
      else $error("bus_ack high outside ST_BUS");

endmodule

bind uart_axil_bridge uart_dem_props u_props (
   .clk     (clk),
   .rst     (rst),
   .bvalid  (bvalid),
   .bready  (bready),
   .rvalid  (rvalid),
   .rready  (rready),
   .rdata   (rdata),
   .bus_ack (bus_ack),
   .state   (state)
);

// File: sim/uart_dem_tb.sv
// Testbench for the UART debug emulator
// Drives AXI4-Lite register accesses and debug_in packets, checks the
// debug_out packets and register reads against a reference model

`timescale 1ns/1ns
`include "uart_dem_macros.svh"

module uart_dem_tb import dii_pkg::*, uart_pkg::*; ();

   localparam logic [15:0] DUT_ID  = 16'h00a5;
   localparam logic [15:0] HOST_ID = 16'h0000;
   // About 60 accesses and 30 packets, each far below 100 cycles with ready gaps
   localparam int MAX_CYCLES  = 20000;
   localparam int DRAIN_LIMIT = 2000;

   logic       clk;
   logic       rst;
   logic [15:0] id;
   logic       irq;
   logic [2:0] awaddr;
   logic       awvalid;
   logic       awready;
   logic [7:0] wdata;
   logic       wvalid;
   logic       wready;
   logic [1:0] bresp;
   logic       bvalid;
   logic       bready;
   logic [2:0] araddr;
   logic       arvalid;
   logic       arready;
   logic [7:0] rdata;
   logic [1:0] rresp;
   logic       rvalid;
   logic       rready;
   dii_word_t  debug_out_data;
   logic       debug_out_last;
   logic       debug_out_valid;
   logic       debug_out_ready;
   dii_word_t  debug_in_data;
   logic       debug_in_last;
   logic       debug_in_valid;
   logic       debug_in_ready;

   // Expected debug_out flits as {last, data}
   logic [16:0]  exp_q[$];
   logic [16:0]  exp_flit;
   logic [15:0]  lfsr = 16'd62;
   logic [255:0] gap_bits;
   logic [7:0]   gap_idx = 8'd0;
   logic         gap_en;
   logic [7:0]   chars[20];
   string        cur_test;
   int           errors;
   int           checks;
   int           tests_run;
   int           tests_failed;
   int           test_err0;
   int           cycles;

   // Reference model of the register file
   logic       m_ier;
   logic [7:0] m_lcr;
   logic [7:0] m_mcr;
   logic [7:0] m_scr;
   logic       m_rx_full;
   logic [7:0] m_rx_char;

   uart_dem_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = 32'd0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic logic [16:0] ref_flit(input int idx, input logic [7:0] ch);
      logic [15:0] w;
      case (idx)
         0:       w = `UART_DEM_DEST;
         1:       w = DUT_ID;
         default: w = {EVT_CHAR, 6'b0, ch};
      endcase
      return {idx == `UART_DEM_PKT_LEN - 1, w};
   endfunction

   function automatic logic [7:0] ref_read(input uart_reg_e a);
      logic [7:0] r;
      r = 8'h00;
      case (a)
         REG_RBR_THR: r = m_rx_full ? m_rx_char : 8'h00;
         REG_IER:     r = {7'b0, m_ier};
         REG_IIR:     r = (m_rx_full && m_ier) ? 8'h04 : 8'h01;
         REG_LCR:     r = m_lcr;
         REG_MCR:     r = m_mcr;
         REG_SCR:     r = m_scr;
         REG_LSR: begin
            // Reads only happen with the transmit path idle
            r[`UART_DEM_LSR_DR]   = m_rx_full;
            r[`UART_DEM_LSR_THRE] = 1'b1;
            r[`UART_DEM_LSR_TEMT] = 1'b1;
         end
         default:     r = 8'h00;
      endcase
      return r;
   endfunction

   task automatic check(input string name, input logic [31:0] want, input logic [31:0] got);
      checks++;
      if (want !== got) begin
         errors++;
         $display("FAIL %s expected %h actual %h", name, want, got);
      end
   endtask

   task automatic axi_write(input logic [2:0] a, input logic [7:0] d,
                            output logic [1:0] resp);
      @(posedge clk);
      awaddr  <= a;
      wdata   <= d;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      bready  <= 1'b1;
      do @(posedge clk); while (!(awready && wready));
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      do @(posedge clk); while (!bvalid);
      resp = bresp;
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [2:0] a, output logic [7:0] d,
                           output logic [1:0] resp);
      @(posedge clk);
      araddr  <= a;
      arvalid <= 1'b1;
      rready  <= 1'b1;
      do @(posedge clk); while (!arready);
      arvalid <= 1'b0;
      do @(posedge clk); while (!rvalid);
      d    = rdata;
      resp = rresp;
      rready <= 1'b0;
   endtask

   task automatic write_reg(input uart_reg_e a, input logic [7:0] d);
      logic [1:0] resp;
      if (a == REG_RBR_THR) begin
         for (int i = 0; i < `UART_DEM_PKT_LEN; i++)
            exp_q.push_back(ref_flit(i, d));
      end
      axi_write(a, d, resp);
      check({cur_test, " bresp"}, 2'b00, resp);
      case (a)
         REG_IER: m_ier = d[0];
         REG_LCR: m_lcr = d;
         REG_MCR: m_mcr = d;
         REG_SCR: m_scr = d;
         default: ;
      endcase
   endtask

   task automatic read_check(input uart_reg_e a);
      logic [7:0] want;
      logic [7:0] data;
      logic [1:0] resp;
      want = ref_read(a);
      axi_read(a, data, resp);
      check($sformatf("%s %s rresp", cur_test, a.name()), 2'b00, resp);
      check($sformatf("%s %s", cur_test, a.name()), want, data);
      if (a == REG_RBR_THR)
         m_rx_full = 1'b0;
   endtask

   task automatic send_flit(input logic [15:0] data, input logic last);
      debug_in_data  <= data;
      debug_in_last  <= last;
      debug_in_valid <= 1'b1;
      do @(posedge clk); while (!debug_in_ready);
   endtask

   task automatic send_packet(input dii_evt_e kind, input logic [7:0] ch);
      @(posedge clk);
      send_flit(DUT_ID, 1'b0);
      send_flit(HOST_ID, 1'b0);
      send_flit({kind, 6'b0, ch}, 1'b1);
      debug_in_valid <= 1'b0;
      if (kind == EVT_CHAR) begin
         m_rx_full = 1'b1;
         m_rx_char = ch;
      end
   endtask

   // irq is registered, so allow a few cycles to settle
   task automatic irq_check();
      logic want;
      int   n;
      want = m_rx_full & m_ier;
      n = 0;
      while (irq !== want && n < 4) begin
         @(posedge clk);
         n++;
      end
      check({cur_test, " irq"}, want, irq);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("%s: %0d expected flits never came out of debug_out", cur_test,
                  exp_q.size());
         exp_q.delete();
      end
   endtask

   task automatic begin_test(input string name);
      cur_test  = name;
      test_err0 = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors > test_err0) begin
         tests_failed++;
         $display("test %s: %0d errors", cur_test, errors - test_err0);
      end else begin
         $display("test %s: ok", cur_test);
      end
   endtask

   // Ready gaps on debug_out come from a precomputed bit pattern
   always @(posedge clk) begin
      if (gap_en) begin
         debug_out_ready <= gap_bits[gap_idx];
         gap_idx         <= gap_idx + 8'd1;
      end else begin
         debug_out_ready <= 1'b1;
      end
   end

   // Compare every debug_out transfer with the next expected flit
   always @(posedge clk) begin
      if (!rst && debug_out_valid && debug_out_ready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("%s: flit %h came out of debug_out with no packet pending",
                     cur_test, debug_out_data);
         end else begin
            exp_flit = exp_q.pop_front();
            check({cur_test, " flit"}, exp_flit, {debug_out_last, debug_out_data});
         end
      end
   end

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
   end

   initial begin
      rst             = 1'b1;
      id              = DUT_ID;
      awaddr          = 3'd0;
      awvalid         = 1'b0;
      wdata           = 8'h00;
      wvalid          = 1'b0;
      bready          = 1'b0;
      araddr          = 3'd0;
      arvalid         = 1'b0;
      rready          = 1'b0;
      debug_out_ready = 1'b1;
      debug_in_data   = 16'h0000;
      debug_in_last   = 1'b0;
      debug_in_valid  = 1'b0;
      gap_en          = 1'b0;
      errors          = 0;
      checks          = 0;
      tests_run       = 0;
      tests_failed    = 0;
      m_ier           = 1'b0;
      m_lcr           = 8'h00;
      m_mcr           = 8'h00;
      m_scr           = 8'h00;
      m_rx_full       = 1'b0;
      m_rx_char       = 8'h00;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      begin_test("tx_packet");
      write_reg(REG_RBR_THR, 8'h41);
      write_reg(REG_RBR_THR, 8'h00);
      write_reg(REG_RBR_THR, 8'hff);
      write_reg(REG_RBR_THR, 8'h7e);
      wait_drain();
      end_test();

      begin_test("tx_backpressure");
      for (int i = 0; i < 256; i++)
         gap_bits[i] = 1'(rand_bits(1));
      for (int i = 0; i < 20; i++)
         chars[i] = 8'(rand_bits(8));
      gap_en <= 1'b1;
      for (int i = 0; i < 20; i++)
         write_reg(REG_RBR_THR, chars[i]);
      wait_drain();
      gap_en <= 1'b0;
      end_test();

      begin_test("rx_char");
      send_packet(EVT_CHAR, 8'(rand_bits(8)));
      read_check(REG_LSR);
      irq_check();
      write_reg(REG_IER, 8'h01);
      irq_check();
      read_check(REG_RBR_THR);
      read_check(REG_LSR);
      irq_check();
      read_check(REG_RBR_THR);
      send_packet(EVT_OTHER, 8'(rand_bits(8)));
      read_check(REG_LSR);
      read_check(REG_RBR_THR);
      irq_check();
      end_test();

      begin_test("reg_readback");
      for (int i = 0; i < 4; i++) begin
         write_reg(REG_SCR, 8'(rand_bits(8)));
         read_check(REG_SCR);
         write_reg(REG_LCR, 8'(rand_bits(8)));
         read_check(REG_LCR);
         write_reg(REG_MCR, 8'(rand_bits(8)));
         read_check(REG_MCR);
      end
      read_check(REG_MSR);
      read_check(REG_IER);
      end_test();

      begin_test("status");
      write_reg(REG_RBR_THR, 8'(rand_bits(8)));
      wait_drain();
      read_check(REG_LSR);
      read_check(REG_IIR);
      send_packet(EVT_CHAR, 8'(rand_bits(8)));
      read_check(REG_IIR);
      irq_check();
      read_check(REG_RBR_THR);
      read_check(REG_IIR);
      end_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: filelist.f
+incdir+hw
hw/dii_pkg.sv
hw/uart_pkg.sv
hw/uart_axil_bridge.sv
hw/uart_16550_regs.sv
hw/dii_char_tx.sv
hw/dii_char_rx.sv
hw/uart_dem_top.sv
sim/uart_dem_props.sv
sim/uart_dem_tb.sv

// File: Bender.yml
package:
  name: uart_dem

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/dii_pkg.sv
      - hw/uart_pkg.sv
      - hw/uart_axil_bridge.sv
      - hw/uart_16550_regs.sv
      - hw/dii_char_tx.sv
      - hw/dii_char_rx.sv
      - hw/uart_dem_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/uart_dem_props.sv
      - sim/uart_dem_tb.sv
